// File: files.f
+incdir+rtl
rtl/mc_pkg.sv
rtl/core_port_if.sv
rtl/reset_sequencer.sv
rtl/proc_core.sv
rtl/output_select.sv
rtl/multicore.sv
sim/multicore_tb.sv

// File: rtl/core_port_if.sv
`timescale 1ns/1ns

interface core_port_if;

	// Release level from the sequencer, the core is held cleared while low
	logic run;

	// Presented block sum
	mc_pkg::data_t data;

	mc_pkg::req_code_e req;
	mc_pkg::out_code_e out_en;

	modport seq (
		output run
	);

	modport core (
		input  run,
		output data,
		output req,
		output out_en
	);

	// Read-only view for the output selector
	modport mon (
		input data,
		input out_en
	);

endinterface

// File: rtl/mc_consts.svh
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// Number of cores sharing the broadcast input
`define MC_NUM_CORES 8

// Width of the signed broadcast word and of every core result
`define MC_DATA_W 31

// Words summed into one result before it is presented
`define MC_BLOCK_LEN 4

// Clock cycles between two successive core releases
`define MC_RELEASE_GAP 10

// Width of the selected core index on the top level
`define MC_SEL_W 4

// Width of the request and output-enable codes
`define MC_CODE_W 4

`endif

// File: rtl/mc_pkg.sv
`include "mc_consts.svh"

package mc_pkg;

	// Broadcast word, core result and selected output all share this type
	typedef logic signed [`MC_DATA_W-1:0] data_t;

	// Request code a core shows while it wants the broadcast word
	typedef enum logic [`MC_CODE_W-1:0] {
		REQ_NONE = 4'd0,
		REQ_DATA = 4'd1
	} req_code_e;

	// Output-enable code, OUT_VALID marks a finished block sum
	typedef enum logic [`MC_CODE_W-1:0] {
		OUT_IDLE  = 4'd0,
		OUT_VALID = 4'd1
	} out_code_e;

endpackage

// File: rtl/multicore.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module multicore (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic signed [`MC_DATA_W-1:0]            io_in,
	output logic signed [`MC_DATA_W-1:0]            io_out,
	output logic [`MC_CODE_W-1:0]                   out_en,
	output logic [`MC_SEL_W-1:0]                    sel_core,
	output logic [`MC_NUM_CORES-1:0][`MC_CODE_W-1:0] req_in,
	output logic [`MC_NUM_CORES-1:0]                core_running
);

	core_port_if core_ports [`MC_NUM_CORES] ();

	reset_sequencer reset_sequencer_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.cores  (core_ports)
	);

	// Every core sees the same broadcast word
	for (genvar k = 0; k < `MC_NUM_CORES; k++) begin : g_core
		proc_core proc_core_inst (
			.clk    (clk),
			.arst_n (arst_n),
			.port   (core_ports[k]),
			.io_in  (io_in)
		);

		assign req_in[k]       = core_ports[k].req;
		assign core_running[k] = core_ports[k].run;
	end

	output_select output_select_inst (
		.cores    (core_ports),
		.io_out   (io_out),
		.out_en   (out_en),
		.sel_core (sel_core)
	);

endmodule

// File: rtl/output_select.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module output_select (
	core_port_if.mon                cores [`MC_NUM_CORES],
	output mc_pkg::data_t           io_out,
	output mc_pkg::out_code_e       out_en,
	output logic [`MC_SEL_W-1:0]    sel_core
);

	logic [`MC_NUM_CORES-1:0] valid;
	mc_pkg::data_t            core_data [`MC_NUM_CORES];

	// Interface arrays only take constant indices, so tap each port once here
	for (genvar i = 0; i < `MC_NUM_CORES; i++) begin : g_tap
		assign valid[i]     = (cores[i].out_en == mc_pkg::OUT_VALID);
		assign core_data[i] = cores[i].data;
	end

	// First match from core 0 upward wins, later valid cores are dropped
	always_comb begin
		logic found;

		found    = 1'b0;
		io_out   = '0;
		out_en   = mc_pkg::OUT_IDLE;
		sel_core = '0;
		for (int i = 0; i < `MC_NUM_CORES; i++) begin
			if (valid[i] && !found) begin
				found    = 1'b1;
				io_out   = core_data[i];
				out_en   = mc_pkg::OUT_VALID;
				sel_core = `MC_SEL_W'(i);
			end
		end
	end

endmodule

// File: rtl/proc_core.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module proc_core (
	input  logic          clk,
	input  logic          arst_n,
	core_port_if.core     port,
	input  mc_pkg::data_t io_in
);

	// Frame is the request window, one present cycle and one idle cycle
	localparam int FRAME_LEN = `MC_BLOCK_LEN + 2;
	localparam int PHASE_W   = $clog2(FRAME_LEN);

	localparam logic [PHASE_W-1:0] PH_LAST_REQ = PHASE_W'(`MC_BLOCK_LEN - 1);
	localparam logic [PHASE_W-1:0] PH_PRESENT  = PHASE_W'(`MC_BLOCK_LEN);
	localparam logic [PHASE_W-1:0] PH_IDLE     = PHASE_W'(`MC_BLOCK_LEN + 1);

	logic [PHASE_W-1:0] phase;
	mc_pkg::data_t      sum;
	mc_pkg::data_t      result;
	logic               requesting;
	logic               presenting;
	logic               last_word;

	assign requesting = port.run && (phase < PH_PRESENT);
	assign presenting = port.run && (phase == PH_PRESENT);
	assign last_word  = requesting && (phase == PH_LAST_REQ);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= '0;
		end else if (!port.run) begin
			phase <= '0;
		end else if (phase == PH_IDLE) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// The running sum restarts from zero for every frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum <= '0;
		end else if (requesting && !last_word) begin
			sum <= sum + io_in;
		end else begin
			sum <= '0;
		end
	end

	// Last word goes straight into the result, wrapping like the sum
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else if (!port.run) begin
			result <= '0;
		end else if (last_word) begin
			result <= sum + io_in;
		end
	end

	assign port.req    = requesting ? mc_pkg::REQ_DATA : mc_pkg::REQ_NONE;
	assign port.out_en = presenting ? mc_pkg::OUT_VALID : mc_pkg::OUT_IDLE;
	assign port.data   = result;

	// A result is presented right after the request window, never while requesting
	assert property (@(posedge clk) disable iff (!arst_n)
		port.out_en == mc_pkg::OUT_VALID |->
			port.req == mc_pkg::REQ_NONE && $past(port.req == mc_pkg::REQ_DATA))
	else $error("valid output not directly after a request window");

	// The present cycle is followed by one quiet cycle before the next window
	assert property (@(posedge clk) disable iff (!arst_n)
		port.out_en == mc_pkg::OUT_VALID |=>
			port.out_en == mc_pkg::OUT_IDLE && port.req == mc_pkg::REQ_NONE)
	else $error("valid output not followed by an idle cycle");

endmodule

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module reset_sequencer (
	input logic      clk,
	input logic      arst_n,
	core_port_if.seq cores [`MC_NUM_CORES]
);

	localparam int IDX_W = $clog2(`MC_NUM_CORES + 1);
	localparam int GAP_W = $clog2(`MC_RELEASE_GAP + 1);

	logic [`MC_NUM_CORES-1:0] run_q;
	logic [IDX_W-1:0]         next_core;
	logic [GAP_W-1:0]         gap_cnt;
	logic                     done;

	assign done = (next_core == IDX_W'(`MC_NUM_CORES));

	// Core 0 is released at the first edge after reset, then one core every gap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run_q     <= '0;
			next_core <= '0;
			gap_cnt   <= '0;
		end else if (!done) begin
			if (gap_cnt == '0) begin
				run_q     <= run_q | (`MC_NUM_CORES'(1) << next_core);
				next_core <= next_core + 1'b1;
				gap_cnt   <= GAP_W'(`MC_RELEASE_GAP - 1);
			end else begin
				gap_cnt <= gap_cnt - 1'b1;
			end
		end
	end

	for (genvar k = 0; k < `MC_NUM_CORES; k++) begin : g_run
		assign cores[k].run = run_q[k];

		// Once released a core stays running until the next reset
		assert property (@(posedge clk) disable iff (!arst_n)
			run_q[k] |=> run_q[k])
		else $error("core %0d run dropped without reset", k);

		// The core below must have been running for a full gap already
		if (k > 0) begin : g_order
			assert property (@(posedge clk) disable iff (!arst_n)
				$rose(run_q[k]) |-> $past(run_q[k-1], `MC_RELEASE_GAP))
			else $error("core %0d released out of order", k);
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the multicore testbench with Verilator.
# Exits with status 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --assert --timescale 1ns/1ns \
	--top-module multicore_tb \
	-f files.f \
	--Mdir obj_dir \
	-o multicore_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/multicore_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'NO ERRORS'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: sim/multicore_tb.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module multicore_tb;

	localparam int FRAME_LEN = `MC_BLOCK_LEN + 2;
	localparam int RUN_LIMIT = `MC_RELEASE_GAP * `MC_NUM_CORES + 20;

	typedef logic [`MC_NUM_CORES-1:0][`MC_CODE_W-1:0] req_vec_t;

	logic                             clk;
	logic                             arst_n;
	logic signed [`MC_DATA_W-1:0]     io_in;
	logic signed [`MC_DATA_W-1:0]     io_out;
	logic [`MC_CODE_W-1:0]            out_en;
	logic [`MC_SEL_W-1:0]             sel_core;
	req_vec_t                         req_in;
	logic [`MC_NUM_CORES-1:0]         core_running;

	int seed = 25735;
	int err_cnt = 0;
	int timeout_cnt = 0;
	int valid_cnt = 0;
	int overlap_cnt = 0;

	// Reference model state
	int                       edge_cnt;
	logic [`MC_NUM_CORES-1:0] exp_run;
	logic [`MC_NUM_CORES-1:0] exp_mask;
	req_vec_t                 exp_req;
	logic [`MC_SEL_W-1:0]     exp_sel;
	mc_pkg::data_t            acc [`MC_NUM_CORES];
	mc_pkg::data_t            last [`MC_NUM_CORES];
	int                       words [`MC_NUM_CORES];

	multicore multicore_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.io_in        (io_in),
		.io_out       (io_out),
		.out_en       (out_en),
		.sel_core     (sel_core),
		.req_in       (req_in),
		.core_running (core_running)
	);

	always #10 clk = ~clk;

	// New broadcast word shortly after every rising edge
	always @(posedge clk) begin
		int rnd;
		#1;
		rnd = $random(seed);
		io_in = rnd[`MC_DATA_W-1:0];
	end

	// Rising edges seen since the last reset release
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			edge_cnt <= 0;
		end else begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	// Core k runs from edge 1 + k * gap and then loops over its six-cycle frame
	always_comb begin
		int pos;
		pos      = 0;
		exp_run  = '0;
		exp_req  = '0;
		exp_mask = '0;
		for (int k = 0; k < `MC_NUM_CORES; k++) begin
			if (edge_cnt >= 1 + `MC_RELEASE_GAP * k) begin
				pos        = (edge_cnt - 1 - `MC_RELEASE_GAP * k) % FRAME_LEN;
				exp_run[k] = 1'b1;
				if (pos < `MC_BLOCK_LEN) begin
					exp_req[k] = mc_pkg::REQ_DATA;
				end
				if (pos == `MC_BLOCK_LEN) begin
					exp_mask[k] = 1'b1;
				end
			end
		end
	end

	// Walk down so the lowest presenting core is the one left in exp_sel
	always_comb begin
		exp_sel = '0;
		for (int k = `MC_NUM_CORES - 1; k >= 0; k--) begin
			if (exp_mask[k]) begin
				exp_sel = `MC_SEL_W'(k);
			end
		end
	end

	// Block sums rebuilt from the request codes and words seen at each edge
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < `MC_NUM_CORES; k++) begin
				acc[k]   <= '0;
				words[k] <= 0;
			end
		end else begin
			for (int k = 0; k < `MC_NUM_CORES; k++) begin
				if (req_in[k] == mc_pkg::REQ_DATA) begin
					if (words[k] == `MC_BLOCK_LEN - 1) begin
						last[k]  <= acc[k] + io_in;
						acc[k]   <= '0;
						words[k] <= 0;
					end else begin
						acc[k]   <= acc[k] + io_in;
						words[k] <= words[k] + 1;
					end
				end else begin
					acc[k]   <= '0;
					words[k] <= 0;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (out_en == mc_pkg::OUT_VALID) begin
			valid_cnt <= valid_cnt + 1;
		end
		if ($countones(exp_mask) > 1) begin
			overlap_cnt <= overlap_cnt + 1;
		end
	end

	a_release: assert property (@(posedge clk) core_running == exp_run)
	else begin
		err_cnt = err_cnt + 1;
		$display("error at %0t: core_running %b, expected %b", $time, core_running, exp_run);
	end

	a_request: assert property (@(posedge clk) req_in == exp_req)
	else begin
		err_cnt = err_cnt + 1;
		$display("error at %0t: req_in %h, expected %h", $time, req_in, exp_req);
	end

	a_valid: assert property (@(posedge clk)
		out_en == ((|exp_mask) ? mc_pkg::OUT_VALID : mc_pkg::OUT_IDLE))
	else begin
		err_cnt = err_cnt + 1;
		$display("error at %0t: out_en %0d, expected mask %b", $time, out_en, exp_mask);
	end

	a_select: assert property (@(posedge clk) (|exp_mask) |-> sel_core == exp_sel)
	else begin
		err_cnt = err_cnt + 1;
		$display("error at %0t: sel_core %0d, expected %0d", $time, sel_core, exp_sel);
	end

	a_quiet: assert property (@(posedge clk)
		!(|exp_mask) |-> (io_out == '0 && sel_core == '0))
	else begin
		err_cnt = err_cnt + 1;
		$display("error at %0t: idle output io_out %0d sel_core %0d", $time, io_out, sel_core);
	end

	a_sum: assert property (@(posedge clk)
		out_en == mc_pkg::OUT_VALID |-> io_out == last[exp_sel])
	else begin
		err_cnt = err_cnt + 1;
		$display("error at %0t: core %0d io_out %0d, expected %0d",
			$time, exp_sel, io_out, last[exp_sel]);
	end

	task automatic wait_edges(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
		end
	endtask

	task automatic wait_all_running(input int limit, output bit ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < limit) begin
			@(negedge clk);
			n = n + 1;
			ok = &core_running;
		end
		if (!ok) begin
			timeout_cnt = timeout_cnt + 1;
			$display("timeout: not all cores were released within %0d cycles", limit);
		end
	endtask

	// Reset lands mid-cycle, outputs must clear without waiting for a clock
	task automatic pulse_reset();
		@(posedge clk);
		#5 arst_n = 1'b0;
		#1;
		assert (core_running == '0 && req_in == '0 && out_en == mc_pkg::OUT_IDLE &&
			io_out == '0 && sel_core == '0)
		else begin
			err_cnt = err_cnt + 1;
			$display("error at %0t: outputs not cleared by asynchronous reset", $time);
		end
		wait_edges(2);
		#1 arst_n = 1'b1;
	endtask

	initial begin
		bit ok;
		clk    = 1'b0;
		arst_n = 1'b1;
		io_in  = '0;
		#2 arst_n = 1'b0;
		wait_edges(3);
		#1 arst_n = 1'b1;
		wait_all_running(RUN_LIMIT, ok);
		if (ok) begin
			wait_edges(120);
			pulse_reset();
			wait_all_running(RUN_LIMIT, ok);
		end
		if (ok) begin
			wait_edges(100);
		end
		// Without results and overlaps the sum and priority checks never fired
		if (valid_cnt == 0 || overlap_cnt == 0) begin
			err_cnt = err_cnt + 1;
			$display("no result or no two results in the same cycle were seen at the output");
		end
		$display("checks failed: %0d, timeouts: %0d, results seen: %0d, overlaps: %0d",
			err_cnt, timeout_cnt, valid_cnt, overlap_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
